// ==== aw_admit.sv ====
`timescale 1ns/1ps

module aw_admit import demux_cfg_pkg::*, axi_wr_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // subordinate-side aw handshake
  input  logic      s_aw_valid_i,
  input  port_sel_t s_aw_sel_i,
  input  id_t       s_aw_id_i,
  output logic      s_aw_ready_o,
  // manager-side aw handshakes
  output port_vec_t m_aw_valid_o,
  input  port_vec_t m_aw_ready_i,
  // id in-flight look-up
  input  port_sel_t lookup_port_i,
  input  logic      lookup_occupied_i,
  input  logic      id_full_i,
  // open w bursts
  input  cnt_t      w_open_i,
  input  port_sel_t w_port_i,
  input  logic      w_open_full_i,
  // first presentation of an admitted aw
  output logic      push_o
);

  logic      lock_q;
  logic      aw_valid;
  logic      aw_ready;
  logic      cnt_ok;
  logic      w_ok;
  logic      id_ok;

  // -------------------------------------------------------------------------
  // admission checks
  // -------------------------------------------------------------------------
  // room left in the id counters and in the open-burst counter
  assign cnt_ok = !id_full_i && !w_open_full_i;
  // w bursts must not interleave, so only the port already open may follow
  assign w_ok   = (w_open_i == '0) || (w_port_i == s_aw_sel_i);
  // same id to a different port would reorder the b responses
  assign id_ok  = !lookup_occupied_i || (lookup_port_i == s_aw_sel_i);

  // -------------------------------------------------------------------------
  // handshake with valid lock
  // -------------------------------------------------------------------------
  always_comb begin
    aw_valid = 1'b0;
    push_o   = 1'b0;
    if (lock_q) begin
      // already pushed, keep valid up until ready
      aw_valid = 1'b1;
    end else if (s_aw_valid_i && cnt_ok && w_ok && id_ok) begin
      aw_valid = 1'b1;
      push_o   = 1'b1;
    end
  end

  assign aw_ready     = m_aw_ready_i[s_aw_sel_i];
  assign s_aw_ready_o = aw_valid & aw_ready;
  assign m_aw_valid_o = aw_valid ? (port_vec_t'(1) << s_aw_sel_i) : '0;

  // set after an unaccepted presentation, cleared at the transfer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
    end else if (aw_valid) begin
      lock_q <= !aw_ready;
    end
  end

endmodule

// ==== axi_wr_demux.sv ====
`timescale 1ns/1ps

module axi_wr_demux import demux_cfg_pkg::*, axi_wr_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // subordinate-side aw
  input  logic                  s_aw_valid_i,
  output logic                  s_aw_ready_o,
  input  id_t                   s_aw_id_i,
  input  addr_t                 s_aw_addr_i,
  input  len_t                  s_aw_len_i,
  input  port_sel_t             s_aw_sel_i,
  // subordinate-side w
  input  logic                  s_w_valid_i,
  output logic                  s_w_ready_o,
  input  data_t                 s_w_data_i,
  input  strb_t                 s_w_strb_i,
  input  logic                  s_w_last_i,
  // subordinate-side b
  output logic                  s_b_valid_o,
  input  logic                  s_b_ready_i,
  output id_t                   s_b_id_o,
  output resp_t                 s_b_resp_o,
  // manager-side aw
  output port_vec_t             m_aw_valid_o,
  input  port_vec_t             m_aw_ready_i,
  output id_t   [NUM_PORTS-1:0] m_aw_id_o,
  output addr_t [NUM_PORTS-1:0] m_aw_addr_o,
  output len_t  [NUM_PORTS-1:0] m_aw_len_o,
  // manager-side w
  output port_vec_t             m_w_valid_o,
  input  port_vec_t             m_w_ready_i,
  output data_t [NUM_PORTS-1:0] m_w_data_o,
  output strb_t [NUM_PORTS-1:0] m_w_strb_o,
  output port_vec_t             m_w_last_o,
  // manager-side b
  input  port_vec_t             m_b_valid_i,
  output port_vec_t             m_b_ready_o,
  input  id_t   [NUM_PORTS-1:0] m_b_id_i,
  input  resp_t [NUM_PORTS-1:0] m_b_resp_i
);

  logic      push;
  logic      pop;
  look_id_t  aw_look;
  look_id_t  b_look;
  port_sel_t lookup_port;
  logic      lookup_occupied;
  logic      id_full;
  cnt_t      w_open;
  port_sel_t w_port;
  logic      w_open_full;

  // -------------------------------------------------------------------------
  // broadcast payloads, only the valids are steered
  // -------------------------------------------------------------------------
  assign m_aw_id_o   = {NUM_PORTS{s_aw_id_i}};
  assign m_aw_addr_o = {NUM_PORTS{s_aw_addr_i}};
  assign m_aw_len_o  = {NUM_PORTS{s_aw_len_i}};
  assign m_w_data_o  = {NUM_PORTS{s_w_data_i}};
  assign m_w_strb_o  = {NUM_PORTS{s_w_strb_i}};
  assign m_w_last_o  = {NUM_PORTS{s_w_last_i}};

  // counters are indexed by the low id bits
  assign aw_look = s_aw_id_i[LOOK_BITS-1:0];
  assign b_look  = s_b_id_o[LOOK_BITS-1:0];

  id_in_flight u_id_in_flight (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .lookup_id_i       (aw_look),
    .lookup_port_o     (lookup_port),
    .lookup_occupied_o (lookup_occupied),
    .full_o            (id_full),
    .push_i            (push),
    .push_id_i         (aw_look),
    .push_port_i       (s_aw_sel_i),
    .pop_i             (pop),
    .pop_id_i          (b_look)
  );

  aw_admit u_aw_admit (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .s_aw_valid_i      (s_aw_valid_i),
    .s_aw_sel_i        (s_aw_sel_i),
    .s_aw_id_i         (s_aw_id_i),
    .s_aw_ready_o      (s_aw_ready_o),
    .m_aw_valid_o      (m_aw_valid_o),
    .m_aw_ready_i      (m_aw_ready_i),
    .lookup_port_i     (lookup_port),
    .lookup_occupied_i (lookup_occupied),
    .id_full_i         (id_full),
    .w_open_i          (w_open),
    .w_port_i          (w_port),
    .w_open_full_i     (w_open_full),
    .push_o            (push)
  );

  w_steer u_w_steer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .push_i        (push),
    .push_port_i   (s_aw_sel_i),
    .s_w_valid_i   (s_w_valid_i),
    .s_w_last_i    (s_w_last_i),
    .s_w_ready_o   (s_w_ready_o),
    .m_w_valid_o   (m_w_valid_o),
    .m_w_ready_i   (m_w_ready_i),
    .w_open_o      (w_open),
    .w_port_o      (w_port),
    .w_open_full_o (w_open_full)
  );

  b_arbiter u_b_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_ready_o (m_b_ready_o),
    .m_b_id_i    (m_b_id_i),
    .m_b_resp_i  (m_b_resp_i),
    .s_b_valid_o (s_b_valid_o),
    .s_b_ready_i (s_b_ready_i),
    .s_b_id_o    (s_b_id_o),
    .s_b_resp_o  (s_b_resp_o),
    .pop_o       (pop)
  );

endmodule

// ==== axi_wr_demux_sva.sv ====
`timescale 1ns/1ps

module axi_wr_demux_sva import demux_cfg_pkg::*, axi_wr_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input port_vec_t m_aw_valid_o,
  input port_vec_t m_aw_ready_i,
  input id_t       s_aw_id_i,
  input logic      s_b_valid_o,
  input logic      s_b_ready_i,
  input id_t       s_b_id_o,
  input resp_t     s_b_resp_o,
  input cnt_t      w_open
);

  // a manager aw valid stays up with its id until accepted
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_aw
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      m_aw_valid_o[p] && !m_aw_ready_i[p] |=> m_aw_valid_o[p] && $stable(s_aw_id_i))
      else $error("manager AW valid dropped or changed before ready");
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(m_aw_valid_o))
    else $error("more than one manager AW valid");

  // lock-in on b
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s_b_valid_o && !s_b_ready_i |=> s_b_valid_o && $stable(s_b_id_o) && $stable(s_b_resp_o))
    else $error("subordinate B changed while stalled");

  // from zero the count only holds or steps up by one push
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (w_open == '0) |=> (w_open <= cnt_t'(1)))
    else $error("open-burst count underflow");

endmodule

bind axi_wr_demux axi_wr_demux_sva u_sva (.*);

// ==== axi_wr_pkg.sv ====
package axi_wr_pkg;

  // -------------------------------------------------------------------------
  // axi write channel fields
  // -------------------------------------------------------------------------
  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ID_W-1:0]     id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  // one strobe per data byte
  typedef logic [DATA_W/8-1:0] strb_t;
  // burst length minus one
  typedef logic [7:0]          len_t;

  // b response codes
  typedef logic [1:0]          resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== b_arbiter.sv ====
`timescale 1ns/1ps

module b_arbiter import demux_cfg_pkg::*, axi_wr_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // manager-side b channels
  input  port_vec_t             m_b_valid_i,
  output port_vec_t             m_b_ready_o,
  input  id_t   [NUM_PORTS-1:0] m_b_id_i,
  input  resp_t [NUM_PORTS-1:0] m_b_resp_i,
  // subordinate-side b channel
  output logic                  s_b_valid_o,
  input  logic                  s_b_ready_i,
  output id_t                   s_b_id_o,
  output resp_t                 s_b_resp_o,
  // pop to the id counters
  output logic                  pop_o
);

  port_sel_t rr_q;
  port_sel_t rr_idx;
  logic      rr_found;
  logic      lock_q;
  port_sel_t lock_idx_q;
  port_sel_t gnt_idx;
  logic      b_xfer;

  // -------------------------------------------------------------------------
  // round-robin search starting at the pointer
  // -------------------------------------------------------------------------
  always_comb begin
    port_sel_t cand;
    rr_idx   = rr_q;
    rr_found = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      // index wraps with the port index width
      cand = rr_q + port_sel_t'(i);
      if (!rr_found && m_b_valid_i[cand]) begin
        rr_idx   = cand;
        rr_found = 1'b1;
      end
    end
  end

  // lock-in keeps the grant while the subordinate side stalls
  assign gnt_idx     = lock_q ? lock_idx_q : rr_idx;
  assign s_b_valid_o = lock_q ? m_b_valid_i[lock_idx_q] : rr_found;
  assign b_xfer      = s_b_valid_o & s_b_ready_i;
  assign m_b_ready_o = b_xfer ? (port_vec_t'(1) << gnt_idx) : '0;

  // payload of the winner, zero while idle
  assign s_b_id_o   = s_b_valid_o ? m_b_id_i[gnt_idx] : '0;
  assign s_b_resp_o = s_b_valid_o ? m_b_resp_i[gnt_idx] : '0;
  assign pop_o      = b_xfer;

  // -------------------------------------------------------------------------
  // pointer and lock-in state
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (b_xfer) begin
      // next search starts one past the winner
      rr_q   <= gnt_idx + port_sel_t'(1);
      lock_q <= 1'b0;
    end else if (s_b_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

// ==== demux_cfg_pkg.sv ====
package demux_cfg_pkg;

  // -------------------------------------------------------------------------
  // port and counter dimensions
  // -------------------------------------------------------------------------

  // manager-side ports of the demux
  localparam int unsigned NUM_PORTS  = 4;
  // width of a port index
  localparam int unsigned PORT_SEL_W = $clog2(NUM_PORTS);

  // low id bits that select an in-flight counter
  localparam int unsigned LOOK_BITS  = 2;
  // one counter per look-up value
  localparam int unsigned NUM_ID_CNT = 1 << LOOK_BITS;

  // in-flight and open-burst counters, all ones means full
  localparam int unsigned CNT_W      = 3;

  // -------------------------------------------------------------------------
  // derived types
  // -------------------------------------------------------------------------
  typedef logic [PORT_SEL_W-1:0] port_sel_t;
  typedef logic [CNT_W-1:0]      cnt_t;
  typedef logic [LOOK_BITS-1:0]  look_id_t;
  typedef logic [NUM_PORTS-1:0]  port_vec_t;

endpackage

// ==== filelist.f ====
demux_cfg_pkg.sv
axi_wr_pkg.sv
id_in_flight.sv
aw_admit.sv
w_steer.sv
b_arbiter.sv
axi_wr_demux.sv
axi_wr_demux_sva.sv
tb_axi_wr_demux.sv

// ==== id_in_flight.sv ====
`timescale 1ns/1ps

module id_in_flight import demux_cfg_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // look-up for the aw presented right now
  input  look_id_t  lookup_id_i,
  output port_sel_t lookup_port_o,
  output logic      lookup_occupied_o,
  output logic      full_o,
  // push on first aw presentation
  input  logic      push_i,
  input  look_id_t  push_id_i,
  input  port_sel_t push_port_i,
  // pop on each subordinate-side b transfer
  input  logic      pop_i,
  input  look_id_t  pop_id_i
);

  // per-id state gathered for the look-up muxes
  port_sel_t               port_all [NUM_ID_CNT];
  logic [NUM_ID_CNT-1:0]   occupied;
  logic [NUM_ID_CNT-1:0]   cnt_full;

  // -------------------------------------------------------------------------
  // one up/down counter and port register per look-up id
  // -------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_ID_CNT; i++) begin : gen_cnt
    cnt_t      cnt_q;
    port_sel_t port_q;
    logic      hit_push;
    logic      hit_pop;

    assign hit_push = push_i && (push_id_i == look_id_t'(i));
    assign hit_pop  = pop_i && (pop_id_i == look_id_t'(i));

    // push and pop on the same id cancel out
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q <= '0;
      end else if (hit_push && !hit_pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (hit_pop && !hit_push) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end

    // target port of the writes of this id, valid while occupied
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        port_q <= '0;
      end else if (hit_push) begin
        port_q <= push_port_i;
      end
    end

    assign port_all[i] = port_q;
    assign occupied[i] = |cnt_q;
    // saturated counter blocks further pushes
    assign cnt_full[i] = &cnt_q;
  end

  // -------------------------------------------------------------------------
  // combinational look-up
  // -------------------------------------------------------------------------
  assign lookup_port_o     = port_all[lookup_id_i];
  assign lookup_occupied_o = occupied[lookup_id_i];
  // any full counter stalls all aw admission
  assign full_o            = |cnt_full;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; status follows the pass message search
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_axi_wr_demux -f filelist.f &&
./obj_dir/Vtb_axi_wr_demux 2>&1 | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }

// ==== tb_axi_wr_demux.sv ====
`timescale 1ns/1ps

module tb_axi_wr_demux import demux_cfg_pkg::*, axi_wr_pkg::*; ();

  localparam int unsigned AW_TOTAL   = 300;
  localparam int unsigned CLK_PERIOD = 4;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic started;

  logic s_aw_valid_i, s_aw_ready_o;
  id_t s_aw_id_i;
  addr_t s_aw_addr_i;
  len_t s_aw_len_i;
  port_sel_t s_aw_sel_i;
  logic s_w_valid_i, s_w_ready_o, s_w_last_i;
  data_t s_w_data_i;
  strb_t s_w_strb_i;
  logic s_b_valid_o, s_b_ready_i;
  id_t s_b_id_o;
  resp_t s_b_resp_o;
  port_vec_t m_aw_valid_o, m_aw_ready_i;
  id_t [NUM_PORTS-1:0] m_aw_id_o;
  addr_t [NUM_PORTS-1:0] m_aw_addr_o;
  len_t [NUM_PORTS-1:0] m_aw_len_o;
  port_vec_t m_w_valid_o, m_w_ready_i, m_w_last_o;
  data_t [NUM_PORTS-1:0] m_w_data_o;
  strb_t [NUM_PORTS-1:0] m_w_strb_o;
  port_vec_t m_b_valid_i, m_b_ready_o;
  id_t [NUM_PORTS-1:0] m_b_id_i;
  resp_t [NUM_PORTS-1:0] m_b_resp_i;

  // handshakes seen at the falling edge, used by the drivers after the next rise
  logic aw_xfer, w_xfer;
  port_vec_t mb_xfer;

  // scoreboard state
  logic [63:0] aw_exp [NUM_PORTS][$];
  id_t b_exp [NUM_PORTS][$];
  port_sel_t wexp_port [$];
  len_t wexp_len [$];
  int unsigned wexp_beat;
  int unsigned infl_cnt [NUM_ID_CNT];
  port_sel_t infl_port [NUM_ID_CNT];
  int unsigned aw_count, b_count;
  logic b_stall_q;
  id_t b_id_q;
  resp_t b_resp_q;

  // subordinate models
  id_t sub_ids [NUM_PORTS][$];
  int unsigned sub_done [NUM_PORTS];
  // manager w driver
  len_t drv_w_len [$];
  int unsigned drv_beat;
  // cycle count for the stress windows
  int unsigned cyc;
  logic stress;

  axi_wr_demux DUT (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // -------------------------------------------------------------------------
  // failure reporting
  // -------------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%0t: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic resp_t port_resp(input int unsigned p);
    return (p % 2 == 1) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  // -------------------------------------------------------------------------
  // monitor and scoreboard, sampled mid-cycle where everything is stable
  // -------------------------------------------------------------------------
  always @(negedge clk_i) begin
    look_id_t look;
    port_sel_t bp;
    logic [63:0] item;
    aw_xfer = s_aw_valid_i && s_aw_ready_o;
    w_xfer  = s_w_valid_i && s_w_ready_o;
    mb_xfer = m_b_valid_i & m_b_ready_o;
    if (!$onehot0(m_aw_valid_o)) abort_run("more than one manager AW valid");
    // subordinate-side aw transfer updates the model first
    if (aw_xfer) begin
      look = s_aw_id_i[LOOK_BITS-1:0];
      foreach (wexp_port[k]) begin
        if (wexp_port[k] != s_aw_sel_i) abort_run("AW accepted with W burst open elsewhere");
      end
      if (infl_cnt[look] != 0 && infl_port[look] != s_aw_sel_i) begin
        abort_run("AW accepted while its ID is in flight to another port");
      end
      if (infl_cnt[look] >= 7) abort_run("AW accepted with 7 writes in flight for its ID");
      infl_cnt[look]++;
      infl_port[look] = s_aw_sel_i;
      aw_exp[s_aw_sel_i].push_back({s_aw_id_i, s_aw_addr_i, s_aw_len_i, 20'h0});
      b_exp[s_aw_sel_i].push_back(s_aw_id_i);
      wexp_port.push_back(s_aw_sel_i);
      wexp_len.push_back(s_aw_len_i);
      drv_w_len.push_back(s_aw_len_i);
      aw_count++;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
        if (aw_exp[p].size() == 0) abort_run("unexpected AW on a manager port");
        item = aw_exp[p].pop_front();
        check_equal("m_aw_id_o", 64'(item[63:60]), 64'(m_aw_id_o[p]));
        check_equal("m_aw_addr_o", 64'(item[59:28]), 64'(m_aw_addr_o[p]));
        check_equal("m_aw_len_o", 64'(item[27:20]), 64'(m_aw_len_o[p]));
        sub_ids[p].push_back(m_aw_id_o[p]);
      end
    end
    // w steering must follow the oldest open burst
    if (m_w_valid_o != '0) begin
      if (wexp_port.size() == 0) abort_run("W valid without an open burst");
      check_equal("m_w_valid_o", 64'(port_vec_t'(1) << wexp_port[0]), 64'(m_w_valid_o));
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (m_w_valid_o[p] && m_w_ready_i[p]) begin
        check_equal("m_w_data_o", 64'(s_w_data_i), 64'(m_w_data_o[p]));
        check_equal("m_w_strb_o", 64'(s_w_strb_i), 64'(m_w_strb_o[p]));
        check_equal("m_w_last_o", 64'(wexp_beat == 32'(wexp_len[0])), 64'(m_w_last_o[p]));
        if (wexp_beat == 32'(wexp_len[0])) begin
          void'(wexp_port.pop_front());
          void'(wexp_len.pop_front());
          wexp_beat = 0;
          sub_done[p]++;
        end else begin
          wexp_beat++;
        end
      end
    end
    // b held stable while stalled
    if (b_stall_q) begin
      check_equal("s_b_valid_o", 64'(1'b1), 64'(s_b_valid_o));
      check_equal("s_b_id_o", 64'(b_id_q), 64'(s_b_id_o));
      check_equal("s_b_resp_o", 64'(b_resp_q), 64'(s_b_resp_o));
    end
    b_stall_q = s_b_valid_o && !s_b_ready_i;
    b_id_q    = s_b_id_o;
    b_resp_q  = s_b_resp_o;
    if (s_b_valid_o && s_b_ready_i) begin
      look = s_b_id_o[LOOK_BITS-1:0];
      if (infl_cnt[look] == 0) abort_run("B returned for an ID with nothing in flight");
      bp = infl_port[look];
      check_equal("s_b_resp_o", 64'(port_resp(32'(bp))), 64'(s_b_resp_o));
      check_equal("s_b_id_o", 64'(b_exp[bp][0]), 64'(s_b_id_o));
      void'(b_exp[bp].pop_front());
      infl_cnt[look]--;
      b_count++;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (mb_xfer[p]) begin
        void'(sub_ids[p].pop_front());
        sub_done[p]--;
      end
    end
  end

  // -------------------------------------------------------------------------
  // manager and subordinate drivers, 1 ns after the rising edge
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin
    #1;
    if (started) begin
      // odd 256-cycle windows block b and tie the port to the low id bits
      // so the id counters run up to full
      stress = ((cyc / 256) % 2) == 1;
      cyc++;
      if (s_aw_valid_i && aw_xfer) s_aw_valid_i = 1'b0;
      if (!s_aw_valid_i && aw_count < AW_TOTAL && $urandom % 3 != 0) begin
        s_aw_valid_i = 1'b1;
        s_aw_id_i    = id_t'($urandom);
        s_aw_addr_i  = addr_t'($urandom);
        s_aw_len_i   = len_t'($urandom % 4);
        if (stress) begin
          s_aw_sel_i = port_sel_t'(s_aw_id_i[LOOK_BITS-1:0]);
        end else begin
          s_aw_sel_i = port_sel_t'($urandom);
        end
      end
      // beat counter advances on each accepted beat
      if (s_w_valid_i && w_xfer) begin
        s_w_valid_i = 1'b0;
        if (s_w_last_i) begin
          void'(drv_w_len.pop_front());
          drv_beat = 0;
        end else begin
          drv_beat++;
        end
      end
      if (!s_w_valid_i && drv_w_len.size() > 0 && $urandom % 4 != 0) begin
        s_w_valid_i = 1'b1;
        s_w_data_i  = data_t'($urandom);
        s_w_strb_i  = strb_t'($urandom);
        s_w_last_i  = (drv_beat == 32'(drv_w_len[0]));
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        m_aw_ready_i[p] = 1'($urandom % 2);
        m_w_ready_i[p]  = 1'($urandom % 2);
        if (m_b_valid_i[p] && mb_xfer[p]) m_b_valid_i[p] = 1'b0;
        if (!m_b_valid_i[p] && sub_ids[p].size() > 0 && sub_done[p] > 0 &&
            $urandom % 3 == 0) begin
          m_b_valid_i[p] = 1'b1;
          m_b_id_i[p]    = sub_ids[p][0];
          m_b_resp_i[p]  = port_resp(p);
        end
      end
      if (stress) begin
        s_b_ready_i = 1'b0;
      end else begin
        s_b_ready_i = 1'($urandom % 2);
      end
    end
  end

  // watchdog sized from the number of writes
  initial begin
    #(AW_TOTAL * 200 * CLK_PERIOD);
    abort_run("watchdog timeout, the writes did not complete");
  end

  initial begin
    logic end_ok;
    void'($urandom(32'hd5f4e6b5));
    started = 1'b0;
    arst_n_i = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_id_i = '0;
    s_aw_addr_i = '0;
    s_aw_len_i = '0;
    s_aw_sel_i = '0;
    s_w_valid_i = 1'b0;
    s_w_data_i = '0;
    s_w_strb_i = '0;
    s_w_last_i = 1'b0;
    s_b_ready_i = 1'b0;
    m_aw_ready_i = '0;
    m_w_ready_i = '0;
    m_b_valid_i = '0;
    m_b_id_i = '0;
    m_b_resp_i = '0;
    aw_xfer = 1'b0;
    w_xfer = 1'b0;
    mb_xfer = '0;
    wexp_beat = 0;
    drv_beat = 0;
    aw_count = 0;
    b_count = 0;
    cyc = 0;
    stress = 1'b0;
    b_stall_q = 1'b0;
    b_id_q = '0;
    b_resp_q = '0;
    for (int i = 0; i < NUM_ID_CNT; i++) begin
      infl_cnt[i] = 0;
      infl_port[i] = '0;
    end
    for (int p = 0; p < NUM_PORTS; p++) sub_done[p] = 0;
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    started = 1'b1;
    while (b_count < AW_TOTAL) @(posedge clk_i);
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    // every queue drained and no stray b presented
    end_ok = (wexp_port.size() == 0) && !s_b_valid_o;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (aw_exp[p].size() != 0 || b_exp[p].size() != 0 || sub_ids[p].size() != 0) begin
        end_ok = 1'b0;
      end
    end
    if (end_ok) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("model queues not empty or a B left pending at the end of the run");
    end
  end

endmodule

// ==== w_steer.sv ====
`timescale 1ns/1ps

module w_steer import demux_cfg_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // aw push from admission
  input  logic      push_i,
  input  port_sel_t push_port_i,
  // subordinate-side w handshake
  input  logic      s_w_valid_i,
  input  logic      s_w_last_i,
  output logic      s_w_ready_o,
  // manager-side w handshakes
  output port_vec_t m_w_valid_o,
  input  port_vec_t m_w_ready_i,
  // open-burst state back to admission
  output cnt_t      w_open_o,
  output port_sel_t w_port_o,
  output logic      w_open_full_o
);

  cnt_t      w_open_q;
  port_sel_t w_port_q;
  port_sel_t w_sel;
  logic      w_sel_valid;
  logic      w_down;

  // -------------------------------------------------------------------------
  // w target selection
  // -------------------------------------------------------------------------
  // stored port while bursts are open, else the port being pushed
  assign w_sel       = (|w_open_q) ? w_port_q : push_port_i;
  assign w_sel_valid = push_i | (|w_open_q);

  assign m_w_valid_o = (w_sel_valid && s_w_valid_i) ? (port_vec_t'(1) << w_sel) : '0;
  assign s_w_ready_o = w_sel_valid & m_w_ready_i[w_sel];
  // a burst closes with its last beat
  assign w_down      = s_w_valid_i & s_w_ready_o & s_w_last_i;

  // -------------------------------------------------------------------------
  // open-burst counter and stored target
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_open_q <= '0;
      w_port_q <= '0;
    end else begin
      // push and last beat in one cycle cancel
      if (push_i && !w_down) begin
        w_open_q <= w_open_q + cnt_t'(1);
      end else if (w_down && !push_i) begin
        w_open_q <= w_open_q - cnt_t'(1);
      end
      if (push_i) begin
        w_port_q <= push_port_i;
      end
    end
  end

  assign w_open_o      = w_open_q;
  assign w_port_o      = w_sel;
  assign w_open_full_o = &w_open_q;

endmodule
